/* nice_core_defines.svh */
`ifndef NICE_CORE_DEFINES_SVH
`define NICE_CORE_DEFINES_SVH

////////////////////////////////////////
// datapath geometry
////////////////////////////////////////
`define NICE_XLEN        32
`define NICE_BUF_DEPTH   8
`define NICE_IDX_W       3

// byte distance between two memory beats
`define NICE_ADDR_STEP   4

////////////////////////////////////////
// custom-3 R-type encodings
////////////////////////////////////////
`define NICE_OPC_CUSTOM3 7'h7b
`define NICE_F3_MEM      3'b010
`define NICE_F3_WORK     3'b000
`define NICE_F7_LABUF    7'b0000001
`define NICE_F7_LPBUF    7'b0000011
`define NICE_F7_SBUF     7'b0000100
`define NICE_F7_WORK     7'b0000101

`endif

/* nice_core_pkg.sv */
`include "nice_core_defines.svh"

package nice_core_pkg;

   typedef logic [`NICE_XLEN-1:0]  nice_word_t;
   typedef logic [`NICE_IDX_W-1:0] nice_idx_t;

   // decoded custom-3 operation
   typedef enum logic [2:0] {
      OP_NONE,
      OP_LABUF,
      OP_LPBUF,
      OP_SBUF,
      OP_WORK,
      OP_ILLEGAL
   } nice_op_e;

   // main sequencing FSM
   typedef enum logic [2:0] {
      S_IDLE,
      S_LOAD,
      S_STORE,
      S_WORK,
      S_RESP
   } nice_state_e;

   // execute unit FSM
   typedef enum logic [2:0] {
      X_IDLE,
      X_FETCH,
      X_ITER,
      X_WRITE,
      X_DONE
   } nice_exec_state_e;

   typedef struct packed {
      nice_word_t inst;
      nice_word_t rs1;
   } nice_req_t;

   // one load beat headed for the A or P buffer
   typedef struct packed {
      logic       valid;
      logic       to_p;
      nice_idx_t  idx;
      nice_word_t data;
   } nice_ld_wr_t;

endpackage

/* nice_cmd_ctrl.sv */
`timescale 1ns/1ps
`include "nice_core_defines.svh"

module nice_cmd_ctrl import nice_core_pkg::*; (
   input  logic       nice_clk,
   input  logic       nice_rst_n,
   input  logic       req_valid,
   input  nice_req_t  req,
   input  logic       mem_cmd_ready,
   input  logic       mem_done,
   input  logic       mem_err,
   input  logic       work_done,
   input  nice_word_t work_result,
   input  logic       rsp_ready,
   output logic       req_ready,
   output logic       mem_start,
   output nice_op_e   op,
   output nice_word_t rs1,
   output logic       work_start,
   output logic       rsp_valid,
   output nice_word_t rsp_rdat,
   output logic       rsp_err,
   output logic       active,
   output logic       mem_holdup
);

   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic        is_mem_op;
   logic        req_hsk;
   nice_state_e state_r;
   nice_state_e state_nxt;
   logic        err_r;
   nice_word_t  rdat_r;

   ////////////////////////////////////////
   // decode
   ////////////////////////////////////////
   assign opcode = req.inst[6:0];
   assign funct3 = req.inst[14:12];
   assign funct7 = req.inst[31:25];

   always_comb begin
      op = OP_NONE;
      if (req_valid) begin
         op = OP_ILLEGAL;
         if (opcode == `NICE_OPC_CUSTOM3 && funct3 == `NICE_F3_MEM) begin
            case (funct7)
               `NICE_F7_LABUF: op = OP_LABUF;
               `NICE_F7_LPBUF: op = OP_LPBUF;
               `NICE_F7_SBUF:  op = OP_SBUF;
               default:        op = OP_ILLEGAL;
            endcase
         end else if (opcode == `NICE_OPC_CUSTOM3 && funct3 == `NICE_F3_WORK &&
                      funct7 == `NICE_F7_WORK) begin
            op = OP_WORK;
         end
      end
   end

   assign is_mem_op = (op == OP_LABUF) || (op == OP_LPBUF) || (op == OP_SBUF);
   assign rs1       = req.rs1;

   // memory ops are taken together with their first command beat
   assign req_ready  = (state_r == S_IDLE) && (is_mem_op ? mem_cmd_ready : 1'b1);
   assign req_hsk    = req_valid && req_ready;
   assign mem_start  = (state_r == S_IDLE) && req_valid && is_mem_op;
   assign work_start = req_hsk && (op == OP_WORK);

   ////////////////////////////////////////
   // main FSM
   ////////////////////////////////////////
   always_comb begin
      state_nxt = state_r;
      case (state_r)
         S_IDLE: begin
            if (req_hsk) begin
               case (op)
                  OP_LABUF, OP_LPBUF: state_nxt = S_LOAD;
                  OP_SBUF:            state_nxt = S_STORE;
                  OP_WORK:            state_nxt = S_WORK;
                  default:            state_nxt = S_RESP;
               endcase
            end
         end
         S_LOAD, S_STORE: if (mem_done) state_nxt = S_RESP;
         S_WORK:          if (work_done) state_nxt = S_RESP;
         S_RESP:          if (rsp_ready) state_nxt = S_IDLE;
         default:         state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge nice_clk) begin
      if (!nice_rst_n) begin
         state_r <= S_IDLE;
         err_r   <= 1'b0;
      end else begin
         state_r <= state_nxt;
         // illegal ops report an error straight away
         if (req_hsk) begin
            err_r <= (op == OP_ILLEGAL);
         end else if (mem_holdup) begin
            err_r <= err_r | mem_err;
         end
      end
   end

   // remainder of the last index, zero for every other op
   always_ff @(posedge nice_clk) begin
      if (req_hsk) begin
         rdat_r <= '0;
      end else if (state_r == S_WORK && work_done) begin
         rdat_r <= work_result;
      end
   end

   assign rsp_valid  = (state_r == S_RESP);
   assign rsp_rdat   = rdat_r;
   assign rsp_err    = err_r;
   assign mem_holdup = (state_r == S_LOAD) || (state_r == S_STORE);
   assign active     = (state_r != S_IDLE) || req_valid;

endmodule

/* nice_icb_master.sv */
`timescale 1ns/1ps
`include "nice_core_defines.svh"

module nice_icb_master import nice_core_pkg::*; (
   input  logic        nice_clk,
   input  logic        nice_rst_n,
   input  logic        mem_start,
   input  nice_op_e    op,
   input  nice_word_t  rs1,
   input  logic        icb_cmd_ready,
   input  logic        icb_rsp_valid,
   input  nice_word_t  icb_rsp_rdata,
   input  logic        icb_rsp_err,
   input  nice_word_t  store_data,
   output logic        mem_cmd_ready,
   output logic        mem_done,
   output logic        mem_err,
   output logic        icb_cmd_valid,
   output nice_word_t  icb_cmd_addr,
   output logic        icb_cmd_read,
   output nice_word_t  icb_cmd_wdata,
   output nice_idx_t   store_idx,
   output nice_ld_wr_t ld_wr
);

   localparam logic [`NICE_IDX_W:0] CMD_BEATS = (`NICE_IDX_W+1)'(`NICE_BUF_DEPTH);
   localparam nice_idx_t            LAST_IDX  = nice_idx_t'(`NICE_BUF_DEPTH - 1);

   logic                  busy_r;
   logic                  is_store_r;
   logic                  to_p_r;
   logic [`NICE_IDX_W:0]  cmd_cnt_r;
   nice_idx_t             rsp_cnt_r;
   nice_word_t            addr_r;
   logic                  cmd_hsk;
   logic                  rsp_fire;
   logic                  cmds_left;

   assign cmds_left = busy_r && (cmd_cnt_r != CMD_BEATS);
   assign cmd_hsk   = icb_cmd_valid && icb_cmd_ready;
   // response channel is always ready
   assign rsp_fire  = busy_r && icb_rsp_valid;

   ////////////////////////////////////////
   // command channel
   ////////////////////////////////////////
   // first beat goes out in the accept cycle, straight from rs1
   assign icb_cmd_valid = mem_start || cmds_left;
   assign icb_cmd_addr  = busy_r ? addr_r : rs1;
   assign icb_cmd_read  = busy_r ? !is_store_r : (op != OP_SBUF);
   assign store_idx     = busy_r ? cmd_cnt_r[`NICE_IDX_W-1:0] : '0;
   assign icb_cmd_wdata = icb_cmd_read ? '0 : store_data;
   assign mem_cmd_ready = icb_cmd_ready;

   // next beat address
   always_ff @(posedge nice_clk) begin
      if (cmd_hsk) begin
         addr_r <= icb_cmd_addr + nice_word_t'(`NICE_ADDR_STEP);
      end
   end

   always_ff @(posedge nice_clk) begin
      if (!nice_rst_n) begin
         busy_r     <= 1'b0;
         is_store_r <= 1'b0;
         to_p_r     <= 1'b0;
         cmd_cnt_r  <= '0;
         rsp_cnt_r  <= '0;
      end else if (mem_start && icb_cmd_ready) begin
         busy_r     <= 1'b1;
         is_store_r <= (op == OP_SBUF);
         to_p_r     <= (op == OP_LPBUF);
         cmd_cnt_r  <= (`NICE_IDX_W+1)'(1);
         rsp_cnt_r  <= '0;
      end else if (busy_r) begin
         if (cmd_hsk) begin
            cmd_cnt_r <= cmd_cnt_r + 1'b1;
         end
         if (rsp_fire) begin
            rsp_cnt_r <= rsp_cnt_r + 1'b1;
         end
         if (mem_done) begin
            busy_r <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // response channel
   ////////////////////////////////////////
   assign mem_done = rsp_fire && (rsp_cnt_r == LAST_IDX);
   assign mem_err  = rsp_fire && icb_rsp_err;

   // load data is written on the response beat itself
   assign ld_wr.valid = rsp_fire && !is_store_r;
   assign ld_wr.to_p  = to_p_r;
   assign ld_wr.idx   = rsp_cnt_r;
   assign ld_wr.data  = icb_rsp_rdata;

endmodule

/* nice_operand_buf.sv */
`timescale 1ns/1ps
`include "nice_core_defines.svh"

module nice_operand_buf import nice_core_pkg::*; (
   input  logic        nice_clk,
   input  logic        nice_rst_n,
   input  nice_ld_wr_t ld_wr,
   input  nice_idx_t   rd_idx,
   output nice_word_t  a_word,
   output nice_word_t  p_word
);

   nice_word_t a_mem [`NICE_BUF_DEPTH];
   nice_word_t p_mem [`NICE_BUF_DEPTH];

   // single write port steered by the target flag
   always_ff @(posedge nice_clk) begin
      if (!nice_rst_n) begin
         for (int i = 0; i < `NICE_BUF_DEPTH; i++) begin
            a_mem[i] <= '0;
            p_mem[i] <= '0;
         end
      end else if (ld_wr.valid) begin
         if (ld_wr.to_p) begin
            p_mem[ld_wr.idx] <= ld_wr.data;
         end else begin
            a_mem[ld_wr.idx] <= ld_wr.data;
         end
      end
   end

   // execute reads A and P of the same index
   assign a_word = a_mem[rd_idx];
   assign p_word = p_mem[rd_idx];

endmodule

/* nice_mod_exec.sv */
`timescale 1ns/1ps
`include "nice_core_defines.svh"

module nice_mod_exec import nice_core_pkg::*; (
   input  logic       nice_clk,
   input  logic       nice_rst_n,
   input  logic       work_start,
   input  nice_word_t a_word,
   input  nice_word_t p_word,
   output nice_idx_t  rd_idx,
   output logic       res_we,
   output nice_idx_t  res_idx,
   output nice_word_t res_data,
   output logic       work_done
);

   localparam int              BIT_W    = $clog2(`NICE_XLEN);
   localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`NICE_XLEN - 1);
   localparam nice_idx_t        LAST_IDX = nice_idx_t'(`NICE_BUF_DEPTH - 1);

   nice_exec_state_e    xstate_r;
   nice_idx_t           idx_r;
   logic [BIT_W-1:0]    bit_cnt_r;
   nice_word_t          a_r;
   nice_word_t          p_r;
   nice_word_t          rem_r;
   logic [`NICE_XLEN:0] rem_shift;
   logic [`NICE_XLEN:0] rem_diff;
   nice_word_t          rem_next;

   ////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////
   always_ff @(posedge nice_clk) begin
      if (!nice_rst_n) begin
         xstate_r  <= X_IDLE;
         idx_r     <= '0;
         bit_cnt_r <= '0;
      end else begin
         case (xstate_r)
            X_IDLE: begin
               if (work_start) begin
                  idx_r    <= '0;
                  xstate_r <= X_FETCH;
               end
            end
            X_FETCH: begin
               bit_cnt_r <= '0;
               xstate_r  <= X_ITER;
            end
            // one quotient bit per cycle
            X_ITER: begin
               bit_cnt_r <= bit_cnt_r + 1'b1;
               if (bit_cnt_r == LAST_BIT) begin
                  xstate_r <= X_WRITE;
               end
            end
            X_WRITE: begin
               if (idx_r == LAST_IDX) begin
                  xstate_r <= X_DONE;
               end else begin
                  idx_r    <= idx_r + 1'b1;
                  xstate_r <= X_FETCH;
               end
            end
            X_DONE:  xstate_r <= X_IDLE;
            default: xstate_r <= X_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////
   // restoring remainder
   ////////////////////////////////////////
   assign rem_shift = {rem_r, a_r[`NICE_XLEN-1]};
   assign rem_diff  = rem_shift - {1'b0, p_r};
   // borrow out means the trial subtract failed
   assign rem_next  = rem_diff[`NICE_XLEN] ? rem_shift[`NICE_XLEN-1:0]
                                           : rem_diff[`NICE_XLEN-1:0];

   // a_r rotates so it holds A again after the last iteration
   always_ff @(posedge nice_clk) begin
      if (xstate_r == X_FETCH) begin
         a_r   <= a_word;
         p_r   <= p_word;
         rem_r <= '0;
      end else if (xstate_r == X_ITER) begin
         a_r   <= {a_r[`NICE_XLEN-2:0], a_r[`NICE_XLEN-1]};
         rem_r <= rem_next;
      end
   end

   assign rd_idx    = idx_r;
   assign res_we    = (xstate_r == X_WRITE);
   assign res_idx   = idx_r;
   // zero modulus passes A through
   assign res_data  = (p_r == '0) ? a_r : rem_r;
   // res_data still holds index 7 here
   assign work_done = (xstate_r == X_DONE);

endmodule

/* nice_result_buf.sv */
`timescale 1ns/1ps
`include "nice_core_defines.svh"

module nice_result_buf import nice_core_pkg::*; (
   input  logic       nice_clk,
   input  logic       nice_rst_n,
   input  logic       res_we,
   input  nice_idx_t  res_idx,
   input  nice_word_t res_data,
   input  nice_idx_t  store_idx,
   output nice_word_t store_data
);

   nice_word_t res_mem [`NICE_BUF_DEPTH];

   always_ff @(posedge nice_clk) begin
      if (!nice_rst_n) begin
         for (int i = 0; i < `NICE_BUF_DEPTH; i++) begin
            res_mem[i] <= '0;
         end
      end else if (res_we) begin
         res_mem[res_idx] <= res_data;
      end
   end

   // store beats read by command index, no wait state
   assign store_data = res_mem[store_idx];

endmodule

/* nice_core_top.sv */
`timescale 1ns/1ps
`include "nice_core_defines.svh"

module nice_core_top import nice_core_pkg::*; (
   input  logic                  nice_clk,
   input  logic                  nice_rst_n,
   output logic                  nice_active,
   output logic                  nice_mem_holdup,
   // processor request
   input  logic                  nice_req_valid,
   output logic                  nice_req_ready,
   input  logic [`NICE_XLEN-1:0] nice_req_inst,
   input  logic [`NICE_XLEN-1:0] nice_req_rs1,
   input  logic [`NICE_XLEN-1:0] nice_req_rs2,
   // processor response
   output logic                  nice_rsp_valid,
   input  logic                  nice_rsp_ready,
   output logic [`NICE_XLEN-1:0] nice_rsp_rdat,
   output logic                  nice_rsp_err,
   // memory command
   output logic                  nice_icb_cmd_valid,
   input  logic                  nice_icb_cmd_ready,
   output logic [`NICE_XLEN-1:0] nice_icb_cmd_addr,
   output logic                  nice_icb_cmd_read,
   output logic [`NICE_XLEN-1:0] nice_icb_cmd_wdata,
   // memory response
   input  logic                  nice_icb_rsp_valid,
   output logic                  nice_icb_rsp_ready,
   input  logic [`NICE_XLEN-1:0] nice_icb_rsp_rdata,
   input  logic                  nice_icb_rsp_err
);

   nice_req_t   req_s;
   logic        mem_start;
   logic        mem_cmd_ready;
   logic        mem_done;
   logic        mem_err;
   nice_op_e    op;
   nice_word_t  rs1;
   logic        work_start;
   logic        work_done;
   nice_idx_t   rd_idx;
   nice_word_t  a_word;
   nice_word_t  p_word;
   logic        res_we;
   nice_idx_t   res_idx;
   nice_word_t  res_data;
   nice_idx_t   store_idx;
   nice_word_t  store_data;
   nice_ld_wr_t ld_wr;

   // rs2 is not used by any of the four ops
   assign req_s.inst         = nice_req_inst;
   assign req_s.rs1          = nice_req_rs1;
   assign nice_icb_rsp_ready = 1'b1;

   nice_cmd_ctrl u_cmd_ctrl (
      .nice_clk      (nice_clk),
      .nice_rst_n    (nice_rst_n),
      .req_valid     (nice_req_valid),
      .req           (req_s),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_done      (mem_done),
      .mem_err       (mem_err),
      .work_done     (work_done),
      .work_result   (res_data),
      .rsp_ready     (nice_rsp_ready),
      .req_ready     (nice_req_ready),
      .mem_start     (mem_start),
      .op            (op),
      .rs1           (rs1),
      .work_start    (work_start),
      .rsp_valid     (nice_rsp_valid),
      .rsp_rdat      (nice_rsp_rdat),
      .rsp_err       (nice_rsp_err),
      .active        (nice_active),
      .mem_holdup    (nice_mem_holdup)
   );

   nice_icb_master u_icb_master (
      .nice_clk      (nice_clk),
      .nice_rst_n    (nice_rst_n),
      .mem_start     (mem_start),
      .op            (op),
      .rs1           (rs1),
      .icb_cmd_ready (nice_icb_cmd_ready),
      .icb_rsp_valid (nice_icb_rsp_valid),
      .icb_rsp_rdata (nice_icb_rsp_rdata),
      .icb_rsp_err   (nice_icb_rsp_err),
      .store_data    (store_data),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_done      (mem_done),
      .mem_err       (mem_err),
      .icb_cmd_valid (nice_icb_cmd_valid),
      .icb_cmd_addr  (nice_icb_cmd_addr),
      .icb_cmd_read  (nice_icb_cmd_read),
      .icb_cmd_wdata (nice_icb_cmd_wdata),
      .store_idx     (store_idx),
      .ld_wr         (ld_wr)
   );

   nice_operand_buf u_operand_buf (
      .nice_clk   (nice_clk),
      .nice_rst_n (nice_rst_n),
      .ld_wr      (ld_wr),
      .rd_idx     (rd_idx),
      .a_word     (a_word),
      .p_word     (p_word)
   );

   nice_mod_exec u_mod_exec (
      .nice_clk   (nice_clk),
      .nice_rst_n (nice_rst_n),
      .work_start (work_start),
      .a_word     (a_word),
      .p_word     (p_word),
      .rd_idx     (rd_idx),
      .res_we     (res_we),
      .res_idx    (res_idx),
      .res_data   (res_data),
      .work_done  (work_done)
   );

   nice_result_buf u_result_buf (
      .nice_clk   (nice_clk),
      .nice_rst_n (nice_rst_n),
      .res_we     (res_we),
      .res_idx    (res_idx),
      .res_data   (res_data),
      .store_idx  (store_idx),
      .store_data (store_data)
   );

endmodule

/* nice_core_checker.sv */
`timescale 1ns/1ps

module nice_core_checker (
   input logic        nice_clk,
   input logic        nice_rst_n,
   input logic        nice_active,
   input logic        nice_mem_holdup,
   input logic        nice_rsp_valid,
   input logic        nice_rsp_ready,
   input logic        nice_icb_cmd_valid,
   input logic        nice_icb_cmd_ready,
   input logic [31:0] nice_icb_cmd_addr
);

   // stalled command keeps valid and address
   cmd_hold_a: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      nice_icb_cmd_valid && !nice_icb_cmd_ready |=>
         nice_icb_cmd_valid && $stable(nice_icb_cmd_addr))
      else $error("icb command changed before ready");

   rsp_hold_a: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      nice_rsp_valid && !nice_rsp_ready |=> nice_rsp_valid)
      else $error("response valid dropped before ready");

   holdup_a: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      nice_mem_holdup |-> nice_active)
      else $error("mem holdup without active");

   // nothing leaves the core while reset is held
   reset_quiet_a: assert property (@(posedge nice_clk)
      !nice_rst_n && $past(!nice_rst_n) |-> !nice_icb_cmd_valid && !nice_rsp_valid)
      else $error("traffic during reset");

endmodule

bind nice_core_top nice_core_checker chk0 (
   .nice_clk           (nice_clk),
   .nice_rst_n         (nice_rst_n),
   .nice_active        (nice_active),
   .nice_mem_holdup    (nice_mem_holdup),
   .nice_rsp_valid     (nice_rsp_valid),
   .nice_rsp_ready     (nice_rsp_ready),
   .nice_icb_cmd_valid (nice_icb_cmd_valid),
   .nice_icb_cmd_ready (nice_icb_cmd_ready),
   .nice_icb_cmd_addr  (nice_icb_cmd_addr)
);

/* nice_core_tb.sv */
`timescale 1ns/1ps
`include "nice_core_defines.svh"

module nice_core_tb;

   localparam int NROWS     = 7;
   localparam int ROW_LIMIT = 400;
   localparam int MAX_CYC   = ROW_LIMIT * NROWS;

   // one instruction of the table with its expected response
   typedef struct packed {
      logic [31:0] inst;
      logic [31:0] rs1;
      logic [31:0] rdat;
      logic        err;
      logic        is_mem;
      logic        hold;
      logic        chk_store;
      logic [3:0]  err_beat;
   } row_t;

   logic        nice_clk = 1'b0;
   logic        nice_rst_n = 1'b0;
   logic        nice_req_valid;
   logic [31:0] nice_req_inst;
   logic [31:0] nice_req_rs1;
   logic [31:0] nice_req_rs2;
   logic        nice_rsp_ready = 1'b0;
   logic        nice_icb_cmd_ready = 1'b0;
   logic        nice_icb_rsp_valid = 1'b0;
   logic [31:0] nice_icb_rsp_rdata = 32'h0;
   logic        nice_icb_rsp_err = 1'b0;
   logic        nice_req_ready;
   logic        nice_rsp_valid;
   logic [31:0] nice_rsp_rdat;
   logic        nice_rsp_err;
   logic        nice_icb_cmd_valid;
   logic [31:0] nice_icb_cmd_addr;
   logic        nice_icb_cmd_read;
   logic [31:0] nice_icb_cmd_wdata;
   logic        nice_icb_rsp_ready;
   logic        nice_active;
   logic        nice_mem_holdup;

   logic [31:0] lfsr = 32'h32fcc278;
   logic [31:0] mem [256];
   logic [32:0] rsp_q [$];
   logic [31:0] cmd_addrs [$];
   logic [31:0] a_val [8];
   logic [31:0] p_val [8];
   row_t        rows [NROWS];
   logic [3:0]  inject_beat = 4'hf;
   logic        hold_rsp = 1'b0;
   logic        outstanding = 1'b0;
   logic        cur_mem = 1'b0;
   int          beats = 0;
   int          rsp_count = 0;
   logic        last_err;
   logic [31:0] last_rdat;
   int          cycles = 0;

   nice_core_top dut0 (.*);

   always #5 nice_clk = ~nice_clk;

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   // taps 32, 22, 2, 1
   function automatic logic next_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] next_word();
      logic [31:0] w;
      for (int i = 0; i < 32; i++) begin
         w[i] = next_bit();
      end
      return w;
   endfunction

   function automatic logic [31:0] make_inst(logic [6:0] f7, logic [2:0] f3);
      return {f7, 5'd3, 5'd2, f3, 5'd1, `NICE_OPC_CUSTOM3};
   endfunction

   // zero modulus leaves A as it is
   function automatic logic [31:0] expect_mod(logic [31:0] a, logic [31:0] p);
      return (p == 32'h0) ? a : a % p;
   endfunction

   task automatic fail_value(string name, logic [31:0] got, logic [31:0] exp);
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic fail_text(string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1);
   endtask

   ////////////////////////////////////////
   // memory model and random stalls
   ////////////////////////////////////////
   always @(posedge nice_clk) begin
      if (!nice_rst_n) begin
         nice_icb_cmd_ready <= 1'b0;
         nice_icb_rsp_valid <= 1'b0;
         nice_rsp_ready     <= 1'b0;
      end else begin
         nice_icb_cmd_ready <= next_bit();
         nice_rsp_ready     <= hold_rsp ? 1'b0 : next_bit();
         if (rsp_q.size() > 0 && next_bit()) begin
            nice_icb_rsp_valid <= 1'b1;
            nice_icb_rsp_rdata <= rsp_q[0][31:0];
            nice_icb_rsp_err   <= rsp_q[0][32];
         end else begin
            nice_icb_rsp_valid <= 1'b0;
         end
      end
   end

   // sampled mid cycle, acts on the handshakes of the coming edge
   always @(negedge nice_clk) begin
      if (nice_rst_n) begin
         assert (nice_active == (outstanding || nice_req_valid))
            else fail_value("nice_active", 32'(nice_active), 32'(outstanding || nice_req_valid));
         assert (nice_mem_holdup == (outstanding && cur_mem && beats < 8))
            else fail_value("nice_mem_holdup", 32'(nice_mem_holdup),
                            32'(outstanding && cur_mem && beats < 8));
         if (nice_req_valid && nice_req_ready) begin
            outstanding = 1'b1;
            cmd_addrs.delete();
            beats = 0;
         end
         if (nice_icb_cmd_valid && nice_icb_cmd_ready) begin
            if (nice_icb_cmd_read) begin
               rsp_q.push_back({4'(cmd_addrs.size()) == inject_beat,
                                mem[nice_icb_cmd_addr[9:2]]});
            end else begin
               mem[nice_icb_cmd_addr[9:2]] = nice_icb_cmd_wdata;
               rsp_q.push_back(33'h0);
            end
            cmd_addrs.push_back(nice_icb_cmd_addr);
         end
         if (nice_icb_rsp_valid) begin
            assert (nice_icb_rsp_ready)
               else fail_value("nice_icb_rsp_ready", 32'(nice_icb_rsp_ready), 32'h1);
            void'(rsp_q.pop_front());
            beats++;
         end
         if (nice_rsp_valid && nice_rsp_ready) begin
            outstanding = 1'b0;
            last_err    = nice_rsp_err;
            last_rdat   = nice_rsp_rdat;
            rsp_count++;
         end
      end
   end

   always @(posedge nice_clk) begin
      cycles++;
      if (cycles >= MAX_CYC) begin
         fail_text("run timed out before all instructions completed");
      end
   end

   ////////////////////////////////////////
   // one table row
   ////////////////////////////////////////
   task automatic run_row(row_t row);
      int start;
      start = rsp_count;
      inject_beat = row.err_beat;
      cur_mem     = row.is_mem;
      @(posedge nice_clk);
      hold_rsp       <= row.hold;
      nice_req_valid <= 1'b1;
      nice_req_inst  <= row.inst;
      nice_req_rs1   <= row.rs1;
      do @(negedge nice_clk); while (!(nice_req_valid && nice_req_ready));
      @(posedge nice_clk);
      nice_req_valid <= 1'b0;
      if (row.hold) begin
         do @(negedge nice_clk); while (!nice_rsp_valid);
         repeat (10) begin
            @(negedge nice_clk);
            assert (nice_rsp_valid)
               else fail_text("response dropped while held back");
            assert (!nice_req_ready)
               else fail_text("request ready while a response is pending");
         end
         @(posedge nice_clk);
         hold_rsp <= 1'b0;
      end
      while (rsp_count == start) @(posedge nice_clk);
      repeat (3) @(posedge nice_clk);
      assert (rsp_count == start + 1)
         else fail_text("response delivered more than once");
      assert (last_err == row.err)
         else fail_value("nice_rsp_err", 32'(last_err), 32'(row.err));
      assert (last_rdat == row.rdat)
         else fail_value("nice_rsp_rdat", last_rdat, row.rdat);
      assert (cmd_addrs.size() == (row.is_mem ? 8 : 0))
         else fail_value("command count", 32'(cmd_addrs.size()), row.is_mem ? 32'd8 : 32'd0);
      foreach (cmd_addrs[k]) begin
         assert (cmd_addrs[k] == row.rs1 + 32'(4 * k))
            else fail_value("nice_icb_cmd_addr", cmd_addrs[k], row.rs1 + 32'(4 * k));
      end
      if (row.chk_store) begin
         for (int k = 0; k < 8; k++) begin
            assert (mem[128 + k] == expect_mod(a_val[k], p_val[k]))
               else fail_value("stored result", mem[128 + k], expect_mod(a_val[k], p_val[k]));
         end
      end
   endtask

   initial begin
      nice_req_valid = 1'b0;
      nice_req_inst  = 32'h0;
      nice_req_rs1   = 32'h0;
      nice_req_rs2   = 32'h0;
      for (int i = 0; i < 256; i++) begin
         mem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3};
      end
      // zero moduli, a modulus above A and random words
      a_val = '{32'd100, 32'd7, 32'd5, next_word(), next_word(), next_word(),
                next_word(), next_word()};
      p_val = '{32'd7, 32'd0, 32'd9, next_word() & 32'hffff, next_word(), 32'd0,
                next_word() >> 20, 32'd3};
      for (int k = 0; k < 8; k++) begin
         mem[k]      = a_val[k];
         mem[64 + k] = p_val[k];
      end
      rows[0] = '{make_inst(`NICE_F7_LABUF, `NICE_F3_MEM), 32'h000, 32'h0, 1'b0, 1'b1,
                  1'b0, 1'b0, 4'hf};
      rows[1] = '{make_inst(`NICE_F7_LPBUF, `NICE_F3_MEM), 32'h100, 32'h0, 1'b0, 1'b1,
                  1'b0, 1'b0, 4'hf};
      rows[2] = '{make_inst(`NICE_F7_WORK, `NICE_F3_WORK), 32'h0,
                  expect_mod(a_val[7], p_val[7]), 1'b0, 1'b0, 1'b0, 1'b0, 4'hf};
      rows[3] = '{make_inst(`NICE_F7_SBUF, `NICE_F3_MEM), 32'h200, 32'h0, 1'b0, 1'b1,
                  1'b1, 1'b1, 4'hf};
      rows[4] = '{make_inst(`NICE_F7_LABUF, `NICE_F3_MEM), 32'h000, 32'h0, 1'b1, 1'b1,
                  1'b0, 1'b0, 4'd3};
      rows[5] = '{make_inst(`NICE_F7_LPBUF, `NICE_F3_MEM), 32'h100, 32'h0, 1'b0, 1'b1,
                  1'b0, 1'b0, 4'hf};
      // unknown funct7
      rows[6] = '{make_inst(7'h7f, `NICE_F3_MEM), 32'h300, 32'h0, 1'b1, 1'b0,
                  1'b0, 1'b0, 4'hf};
      repeat (8) @(posedge nice_clk);
      nice_rst_n <= 1'b1;
      for (int r = 0; r < NROWS; r++) begin
         run_row(rows[r]);
      end
      $display("Verification passed");
      $finish;
   end

endmodule

/* nice_core.f */
+incdir+.
nice_core_pkg.sv
nice_cmd_ctrl.sv
nice_icb_master.sv
nice_operand_buf.sv
nice_mod_exec.sv
nice_result_buf.sv
nice_core_top.sv
nice_core_checker.sv
nice_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= nice_core_tb
RTL_TOP   ?= nice_core_top
FLIST     ?= nice_core.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
